/* source/fifo_pkg.sv */
package fifo_pkg;

  // Widest pointer the conversion functions take.
  parameter int PTR_W_MAX = 16;

  // ##########################################################
  // Flag groups, one per clock domain
  // ##########################################################

  typedef struct packed {
    logic full;
    logic afull;
  } wr_flags_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_flags_t;

  // ##########################################################
  // Pointer code conversion
  // ##########################################################

  function automatic logic [PTR_W_MAX-1:0] bin2gray(input logic [PTR_W_MAX-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [PTR_W_MAX-1:0] gray2bin(input logic [PTR_W_MAX-1:0] gray);
    logic [PTR_W_MAX-1:0] bin;
    bin[PTR_W_MAX-1] = gray[PTR_W_MAX-1];
    for (int i = PTR_W_MAX - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // Running XOR from the top.
    end
    return bin;
  endfunction

endpackage

/* source/fifo_gray_sync.sv */
`timescale 1ns/1ps

module fifo_gray_sync #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_WIDTH:0] gray_in,
  output logic [ADDR_WIDTH:0] bin_out
);

  localparam int PW = fifo_pkg::PTR_W_MAX;

  logic [ADDR_WIDTH:0] sync1;
  logic [ADDR_WIDTH:0] sync2;
  logic [PW-1:0]       gray_ext;
  logic [PW-1:0]       bin_ext;

  // ##########################################################
  // Two flops on the destination clock
  // ##########################################################

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync1 <= '0;
      sync2 <= '0;
    end else begin
      sync1 <= gray_in; // May go metastable.
      sync2 <= sync1;
    end
  end

  // Zero extension leaves the lower binary bits intact.
  assign gray_ext = PW'(sync2);
  assign bin_ext  = fifo_pkg::gray2bin(gray_ext);
  assign bin_out  = bin_ext[ADDR_WIDTH:0];

endmodule

/* source/fifo_wr_ctrl.sv */
`timescale 1ns/1ps

module fifo_wr_ctrl #(
  parameter int ADDR_WIDTH = 4,
  parameter int FIFO_DEPTH = 16,
  parameter int FIFO_AFULL = 14
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH:0]   rd_gray,
  output logic                  wr_push,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic [ADDR_WIDTH:0]   wr_gray,
  output fifo_pkg::wr_flags_t   flags
);

  localparam int PW = fifo_pkg::PTR_W_MAX;

  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [PW-1:0]       gray_nxt_ext;
  logic [ADDR_WIDTH:0] rd_bin_sync;
  logic [ADDR_WIDTH:0] level;

  // ##########################################################
  // Read pointer brought into the write domain
  // ##########################################################

  fifo_gray_sync #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_rd_sync (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_bin_sync)
  );

  // ##########################################################
  // Write pointer
  // ##########################################################

  assign wr_push    = wr_en & ~flags.full; // Drop writes while full.
  assign wr_bin_nxt = wr_bin + (ADDR_WIDTH + 1)'(wr_push);
  assign wr_addr    = wr_bin[ADDR_WIDTH-1:0];

  assign gray_nxt_ext = fifo_pkg::bin2gray(PW'(wr_bin_nxt));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= gray_nxt_ext[ADDR_WIDTH:0]; // One bit per edge.
    end
  end

  // ##########################################################
  // Flags
  // ##########################################################

  // Stale read pointer only overstates the level.
  assign level = wr_bin_nxt - rd_bin_sync;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      flags <= '0;
    end else begin
      flags.full  <= (level == (ADDR_WIDTH + 1)'(FIFO_DEPTH));
      flags.afull <= (level >= (ADDR_WIDTH + 1)'(FIFO_AFULL));
    end
  end

endmodule

/* source/fifo_rd_ctrl.sv */
`timescale 1ns/1ps

module fifo_rd_ctrl #(
  parameter int ADDR_WIDTH  = 4,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_gray,
  output logic                  rd_pop,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [ADDR_WIDTH:0]   rd_gray,
  output fifo_pkg::rd_flags_t   flags
);

  localparam int PW = fifo_pkg::PTR_W_MAX;

  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [PW-1:0]       gray_nxt_ext;
  logic [ADDR_WIDTH:0] wr_bin_sync;
  logic [ADDR_WIDTH:0] level;

  // ##########################################################
  // Write pointer brought into the read domain
  // ##########################################################

  fifo_gray_sync #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_wr_sync (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_bin_sync)
  );

  // ##########################################################
  // Read pointer
  // ##########################################################

  assign rd_pop     = rd_en & ~flags.empty; // Ignore reads while empty.
  assign rd_bin_nxt = rd_bin + (ADDR_WIDTH + 1)'(rd_pop);
  assign rd_addr    = rd_bin[ADDR_WIDTH-1:0];

  assign gray_nxt_ext = fifo_pkg::bin2gray(PW'(rd_bin_nxt));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= gray_nxt_ext[ADDR_WIDTH:0];
    end
  end

  // ##########################################################
  // Flags
  // ##########################################################

  // Stale write pointer only understates the level.
  assign level = wr_bin_sync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      flags.empty  <= 1'b1;
      flags.aempty <= 1'b1;
    end else begin
      flags.empty  <= (level == '0);
      flags.aempty <= (level <= (ADDR_WIDTH + 1)'(FIFO_AEMPTY));
    end
  end

endmodule

/* source/fifo_dual_port_ram.sv */
`timescale 1ns/1ps

module fifo_dual_port_ram #(
  parameter int DATA_WIDTH = 8,
  parameter int FIFO_DEPTH = 16,
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  wr_clk,
  input  logic                  wr_push,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_pop,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // ##########################################################
  // Write port
  // ##########################################################

  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ##########################################################
  // Read port
  // ##########################################################

  // Holds the last word until the next pop.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_pop) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* source/async_fifo.sv */
`timescale 1ns/1ps

module async_fifo #(
  parameter int DATA_WIDTH  = 8,
  parameter int FIFO_DEPTH  = 16,
  parameter int FIFO_AFULL  = FIFO_DEPTH - 2,
  parameter int FIFO_AEMPTY = 2
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  afull,
  output logic                  empty,
  output logic                  aempty
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic                  wr_push;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [ADDR_WIDTH:0]   wr_gray;
  fifo_pkg::wr_flags_t   wr_flags;

  logic                  rd_pop;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [ADDR_WIDTH:0]   rd_gray;
  fifo_pkg::rd_flags_t   rd_flags;

  // ##########################################################
  // Write domain
  // ##########################################################

  fifo_wr_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH),
    .FIFO_AFULL (FIFO_AFULL)
  ) u_wr_ctrl (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .rd_gray  (rd_gray),
    .wr_push  (wr_push),
    .wr_addr  (wr_addr),
    .wr_gray  (wr_gray),
    .flags    (wr_flags)
  );

  // ##########################################################
  // Read domain
  // ##########################################################

  fifo_rd_ctrl #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) u_rd_ctrl (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_pop   (rd_pop),
    .rd_addr  (rd_addr),
    .rd_gray  (rd_gray),
    .flags    (rd_flags)
  );

  fifo_dual_port_ram #(
    .DATA_WIDTH (DATA_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram (
    .wr_clk   (wr_clk),
    .wr_push  (wr_push),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_pop   (rd_pop),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  assign full   = wr_flags.full;
  assign afull  = wr_flags.afull;
  assign empty  = rd_flags.empty;
  assign aempty = rd_flags.aempty; // Each flag stays in its own domain.

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real WR_PERIOD  = 11.0,
  parameter real RD_PERIOD  = 8.0,
  parameter int  RST_CYCLES = 3
) (
  output logic wr_clk,
  output logic rd_clk,
  output logic wr_rst_n,
  output logic rd_rst_n
);

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2.0) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(RD_PERIOD / 2.0) rd_clk = ~rd_clk;
  end

  // Release on a falling edge, clear of the flops.
  initial begin
    wr_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge wr_clk);
    @(negedge wr_clk);
    wr_rst_n = 1'b1;
  end

  initial begin
    rd_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge rd_clk);
    @(negedge rd_clk);
    rd_rst_n = 1'b1;
  end

endmodule

/* sim/async_fifo_properties.sv */
`timescale 1ns/1ps

module async_fifo_properties #(
  parameter int ADDR_WIDTH = 4
) (
  input logic                wr_clk,
  input logic                wr_rst_n,
  input logic                rd_clk,
  input logic                rd_rst_n,
  input logic                full,
  input logic                empty,
  input logic [ADDR_WIDTH:0] wr_gray,
  input logic [ADDR_WIDTH:0] rd_gray
);

  int fail_count = 0; // Watched by the testbench.

  // ##########################################################
  // Pointers hold under back-pressure
  // ##########################################################

  a_no_push_when_full : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |=> $stable(wr_gray)
  ) else begin
    $error("Write pointer advanced while full.");
    fail_count++;
  end

  a_no_pop_when_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) empty |=> $stable(rd_gray)
  ) else begin
    $error("Read pointer advanced while empty.");
    fail_count++;
  end

  a_not_full_and_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n || !wr_rst_n) !(full && empty)
  ) else begin
    $error("Full and empty high together.");
    fail_count++;
  end

  // ##########################################################
  // Gray pointers move one bit at a time
  // ##########################################################

  a_wr_gray_step : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) $countones(wr_gray ^ $past(wr_gray)) <= 1
  ) else begin
    $error("Write Gray pointer changed more than one bit.");
    fail_count++;
  end

  a_rd_gray_step : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) $countones(rd_gray ^ $past(rd_gray)) <= 1
  ) else begin
    $error("Read Gray pointer changed more than one bit.");
    fail_count++;
  end

endmodule

/* sim/async_fifo_tb.sv */
`timescale 1ns/1ps

module async_fifo_tb;

  localparam int DATA_WIDTH    = 8;
  localparam int FIFO_DEPTH    = 16;
  localparam int FIFO_AFULL    = 14;
  localparam int FIFO_AEMPTY   = 2;
  localparam int NUM_PHASES    = 11;
  localparam int SETTLE_CYCLES = 6;  // Of wr_clk, the slower clock.
  localparam int DRIVE_DELAY   = 1;

  typedef struct packed {
    int n_wr;
    int n_rd;
    bit rnd;        // Random strobes on both sides.
    int exp_level;  // Negative when traffic is random.
    bit exp_full;
    bit exp_afull;
    bit exp_empty;
    bit exp_aempty;
  } phase_t;

  logic                  wr_clk;
  logic                  rd_clk;
  logic                  wr_rst_n;
  logic                  rd_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  afull;
  logic                  empty;
  logic                  aempty;

  logic [DATA_WIDTH-1:0] model_q [$];
  logic [DATA_WIDTH-1:0] rd_expect = '0;
  logic [DATA_WIDTH-1:0] rd_next;
  bit                    rd_pending = 1'b0;
  bit                    full_due = 1'b0;
  integer                seed = 15626;
  int                    timeout_ns = 0;
  phase_t                phases [NUM_PHASES];

  tb_clock_gen #(
    .WR_PERIOD  (11.0),
    .RD_PERIOD  (8.0),
    .RST_CYCLES (3)
  ) u_clk (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_rst_n (rd_rst_n)
  );

  async_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .FIFO_DEPTH  (FIFO_DEPTH),
    .FIFO_AFULL  (FIFO_AFULL),
    .FIFO_AEMPTY (FIFO_AEMPTY)
  ) dut (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  bind async_fifo async_fifo_properties #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_props (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .full     (full),
    .empty    (empty),
    .wr_gray  (wr_gray),
    .rd_gray  (rd_gray)
  );

  // ##########################################################
  // Failure handling
  // ##########################################################

  task automatic halt_on_failure();
    $display("Verification failed");
    $fatal(1, "Stopped at first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
      halt_on_failure();
    end
  endtask

  // ##########################################################
  // Phase table
  // ##########################################################

  task automatic fill_phase_table();
    phases[0]  = '{3,  0,  1'b0, 3,  1'b0, 1'b0, 1'b0, 1'b0};
    phases[1]  = '{0,  1,  1'b0, 2,  1'b0, 1'b0, 1'b0, 1'b1};
    phases[2]  = '{0,  4,  1'b0, 0,  1'b0, 1'b0, 1'b1, 1'b1}; // Two reads while empty.
    phases[3]  = '{13, 0,  1'b0, 13, 1'b0, 1'b0, 1'b0, 1'b0};
    phases[4]  = '{1,  0,  1'b0, 14, 1'b0, 1'b1, 1'b0, 1'b0};
    phases[5]  = '{0,  14, 1'b0, 0,  1'b0, 1'b0, 1'b1, 1'b1};
    phases[6]  = '{20, 0,  1'b0, 16, 1'b1, 1'b1, 1'b0, 1'b0}; // Four writes dropped.
    phases[7]  = '{0,  16, 1'b0, 0,  1'b0, 1'b0, 1'b1, 1'b1};
    phases[8]  = '{0,  3,  1'b0, 0,  1'b0, 1'b0, 1'b1, 1'b1};
    phases[9]  = '{60, 60, 1'b1, -1, 1'b0, 1'b0, 1'b0, 1'b0};
    phases[10] = '{0,  20, 1'b0, 0,  1'b0, 1'b0, 1'b1, 1'b1}; // Drain.
  endtask

  function automatic int total_ops();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM_PHASES; i++) begin
      sum += phases[i].n_wr + phases[i].n_rd;
    end
    return sum;
  endfunction

  // ##########################################################
  // Write and read sides
  // ##########################################################

  task automatic write_step(input bit en, input bit wr_only);
    @(posedge wr_clk);
    #(DRIVE_DELAY);
    if (full_due) begin
      check_value("full", full, 1'b1); // Set by the edge that took the last word.
      full_due = 1'b0;
    end
    wr_en   = en;
    wr_data = DATA_WIDTH'($random(seed));
    if (en && !full) begin
      model_q.push_back(wr_data);
      if (wr_only && model_q.size() == FIFO_DEPTH) begin
        full_due = 1'b1;
      end
    end
  endtask

  task automatic write_burst(input int attempts, input bit rnd, input bit wr_only);
    int done;
    bit en;
    done = 0;
    while (done < attempts) begin
      en = rnd ? ($random(seed) & 1) : 1'b1;
      write_step(en, wr_only);
      if (en) done++;
    end
    write_step(1'b0, wr_only);
  endtask

  // rd_data shows the word popped one rd_clk earlier.
  task automatic read_step(input bit en);
    @(posedge rd_clk);
    #(DRIVE_DELAY);
    if (rd_pending) begin
      rd_expect  = rd_next;
      rd_pending = 1'b0;
    end
    check_value("rd_data", rd_data, rd_expect);
    rd_en = en;
    if (en && !empty) begin
      if (model_q.size() == 0) begin
        $display("Read accepted at %0t while the reference model holds no data.", $time);
        halt_on_failure();
      end else begin
        rd_next    = model_q.pop_front();
        rd_pending = 1'b1;
      end
    end
  endtask

  task automatic read_burst(input int attempts, input bit rnd);
    int done;
    bit en;
    done = 0;
    while (done < attempts) begin
      en = rnd ? ($random(seed) & 1) : 1'b1;
      read_step(en);
      if (en) done++;
    end
    read_step(1'b0);
  endtask

  task automatic run_phase(input phase_t ph);
    int lvl;
    fork
      write_burst(ph.n_wr, ph.rnd, ph.n_rd == 0);
      read_burst(ph.n_rd, ph.rnd);
    join
    repeat (SETTLE_CYCLES) @(posedge wr_clk);
    #(DRIVE_DELAY);
    lvl = model_q.size();
    if (ph.exp_level >= 0) begin
      check_value("level", lvl, ph.exp_level);
      check_value("full", full, ph.exp_full);
      check_value("afull", afull, ph.exp_afull);
      check_value("empty", empty, ph.exp_empty);
      check_value("aempty", aempty, ph.exp_aempty);
    end
    check_value("full", full, lvl == FIFO_DEPTH);
    check_value("afull", afull, lvl >= FIFO_AFULL);
    check_value("empty", empty, lvl == 0);
    check_value("aempty", aempty, lvl <= FIFO_AEMPTY);
  endtask

  // ##########################################################
  // Main sequence and watchdogs
  // ##########################################################

  initial begin
    wr_en   = 1'b0;
    wr_data = '0;
    rd_en   = 1'b0;
    fill_phase_table();
    timeout_ns = total_ops() * 40 + NUM_PHASES * 100 + 1000;
    wait (wr_rst_n === 1'b1 && rd_rst_n === 1'b1);
    @(posedge rd_clk);
    #(DRIVE_DELAY);
    check_value("empty", empty, 1'b1);
    check_value("aempty", aempty, 1'b1);
    check_value("full", full, 1'b0);
    check_value("afull", afull, 1'b0);
    check_value("rd_data", rd_data, '0);
    for (int p = 0; p < NUM_PHASES; p++) begin
      run_phase(phases[p]);
    end
    $display("Verification passed");
    $finish;
  end

  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("Timeout after %0d ns, the test sequence did not complete.", timeout_ns);
    halt_on_failure();
  end

  initial begin
    wait (dut.u_props.fail_count != 0);
    $display("A bound assertion on the FIFO pointers or flags fired at %0t.", $time);
    halt_on_failure();
  end

endmodule

/* async_fifo.f */
source/fifo_pkg.sv
source/fifo_gray_sync.sv
source/fifo_wr_ctrl.sv
source/fifo_rd_ctrl.sv
source/fifo_dual_port_ram.sv
source/async_fifo.sv
sim/tb_clock_gen.sv
sim/async_fifo_properties.sv
sim/async_fifo_tb.sv
